// File: bench/switch_checks.svh
`ifndef SWITCH_CHECKS_SVH
`define SWITCH_CHECKS_SVH

//////////////////////////////////////////////////
// failure reporting and compares
//////////////////////////////////////////////////

task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on the first error");
endtask

task automatic check_src_beat(input string name, input src_beat_t exp, input src_beat_t act);
    if (act !== exp) begin
        abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    end
endtask

task automatic check_link_beat(input string name, input link_beat_t exp, input link_beat_t act);
    if (act !== exp) begin
        abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    end
endtask

task automatic check_th(input string name, input th_t exp, input th_t act);
    if (act !== exp) begin
        abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    end
endtask

//////////////////////////////////////////////////
// stimulus helpers
//////////////////////////////////////////////////

// data carries test tag, source and beat index so every beat is unique
function automatic src_beat_t make_beat(input int src, input int idx, input int len);
    src_beat_t b;
    b.data = {8'(test_tag), 8'(src), 16'(idx)};
    b.keep = 4'hf >> (idx % 4);
    b.last = (idx == len - 1);
    b.user = 2'(idx + src);
    return b;
endfunction

// sends one upstream frame and holds each beat until its ready is seen
task automatic send_frame(input int src, input int nbeats);
    for (int i = 0; i < nbeats; i++) begin
        @(posedge axis_clk);
        beat_drv[src]  <= make_beat(src, i, nbeats);
        valid_drv[src] <= 1'b1;
        do @(negedge axis_clk); while (!src_rdy[src]);
    end
    @(posedge axis_clk);
    valid_drv[src] <= 1'b0;
endtask

task automatic send_link(input link_beat_t b);
    @(posedge axis_clk);
    link_in       <= b;
    link_in_valid <= 1'b1;
    do @(negedge axis_clk); while (!link_in_ready);
endtask

// address and data offered together for one cycle
task automatic lite_write(input logic [`SW_LITE_ADDR_WIDTH-1:0] addr,
                          input logic [`SW_DATA_WIDTH-1:0] data, input logic en);
    @(posedge axis_clk);
    lite_wr.addr <= addr;
    lite_wr.data <= data;
    lite_wr.strb <= 4'hf;
    lite_awvalid <= 1'b1;
    lite_wvalid  <= 1'b1;
    cfg_enable   <= en;
    @(negedge axis_clk);
    if (lite_awready !== en || lite_wready !== en) begin
        abort_run($sformatf("register write to %h: awready/wready did not follow enable %b",
                            addr, en));
    end
    @(posedge axis_clk);
    lite_awvalid <= 1'b0;
    lite_wvalid  <= 1'b0;
    cfg_enable   <= 1'b0;
endtask

task automatic sample_th(output th_t value);
    @(negedge axis_clk);
    if (lite_arready !== 1'b1 || lite_rvalid !== 1'b1) begin
        abort_run("register read: arready or rvalid was not held high");
    end
    if (lite_rdata[`SW_DATA_WIDTH-1:4] !== '0) begin
        abort_run("register read returned nonzero upper bits");
    end
    value = th_t'(lite_rdata[3:0]);
endtask

`endif

// File: bench/switch_tb.sv
`timescale 1ns/10ps

`include "switch_defines.svh"

module switch_tb
    import axis_pkg::*;
    import cfg_pkg::*;
();

    // limit well above the length of all tests
    localparam int MAX_CYCLES = 5000;

    logic                      axis_clk;
    logic                      axi_reset_n;
    src_beat_t                 beat_drv [3];
    logic [2:0]                valid_drv;
    logic [2:0]                src_rdy;
    link_beat_t                link_out;
    logic                      link_out_valid;
    logic                      link_out_ready;
    link_beat_t                link_in;
    logic                      link_in_valid;
    logic                      link_in_ready;
    src_beat_t                 up_out;
    src_beat_t                 aa_out;
    logic                      up_out_valid;
    logic                      aa_out_valid;
    logic                      up_out_ready;
    logic                      aa_out_ready;
    lite_wr_t                  lite_wr;
    logic                      lite_awvalid;
    logic                      lite_wvalid;
    logic                      lite_awready;
    logic                      lite_wready;
    logic                      lite_arvalid;
    logic                      lite_arready;
    logic                      lite_rvalid;
    logic [`SW_DATA_WIDTH-1:0] lite_rdata;
    logic                      lite_rready;
    logic                      cfg_enable;

    int         seed = 35793;
    int         cycles = 0;
    int         test_tag = 0;
    // arbiter rotation model starts at source 0 after reset
    int         rr_start = 0;
    link_beat_t got_link [$];
    src_beat_t  got_up [$];
    src_beat_t  got_aa [$];

    `include "switch_checks.svh"

    axis_switch_top uut (
        .axis_clk       (axis_clk),
        .axi_reset_n    (axi_reset_n),
        .up_beat        (beat_drv[0]),
        .up_valid       (valid_drv[0]),
        .up_ready       (src_rdy[0]),
        .aa_beat        (beat_drv[1]),
        .aa_valid       (valid_drv[1]),
        .aa_ready       (src_rdy[1]),
        .la_beat        (beat_drv[2]),
        .la_valid       (valid_drv[2]),
        .la_ready       (src_rdy[2]),
        .link_out       (link_out),
        .link_out_valid (link_out_valid),
        .link_out_ready (link_out_ready),
        .link_in        (link_in),
        .link_in_valid  (link_in_valid),
        .link_in_ready  (link_in_ready),
        .up_out         (up_out),
        .up_out_valid   (up_out_valid),
        .up_out_ready   (up_out_ready),
        .aa_out         (aa_out),
        .aa_out_valid   (aa_out_valid),
        .aa_out_ready   (aa_out_ready),
        .lite_wr        (lite_wr),
        .lite_awvalid   (lite_awvalid),
        .lite_wvalid    (lite_wvalid),
        .lite_awready   (lite_awready),
        .lite_wready    (lite_wready),
        .lite_arvalid   (lite_arvalid),
        .lite_arready   (lite_arready),
        .lite_rvalid    (lite_rvalid),
        .lite_rdata     (lite_rdata),
        .lite_rready    (lite_rready),
        .cfg_enable     (cfg_enable)
    );

    initial begin
        axis_clk = 1'b0;
        forever #10 axis_clk = ~axis_clk;
    end

    always @(posedge axis_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run("timeout: the tests did not finish within the cycle limit");
        end
    end

    //////////////////////////////////////////////////
    // transfer monitors
    //////////////////////////////////////////////////

    // valid and ready are settled at the falling edge
    initial begin
        forever begin
            @(negedge axis_clk);
            if (link_out_valid && link_out_ready) got_link.push_back(link_out);
            if (up_out_valid && up_out_ready) got_up.push_back(up_out);
            if (aa_out_valid && aa_out_ready) got_aa.push_back(aa_out);
            // the port that is not selected carries an all-zero beat
            if (aa_out_valid) check_src_beat("unselected up port", '0, up_out);
            if (up_out_valid) check_src_beat("unselected aa port", '0, aa_out);
        end
    end

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic config_regs();
        th_t value;
        sample_th(value);
        check_th("cfg_reset", 4'd6, value);
        lite_write(15'h0, 32'd9, 1'b1);
        sample_th(value);
        check_th("cfg_write", 4'd9, value);
        lite_write(15'h0, 32'd5, 1'b0);
        sample_th(value);
        check_th("cfg_disabled", 4'd9, value);
        lite_write(15'h4, 32'd3, 1'b1);
        sample_th(value);
        check_th("cfg_other_addr", 4'd9, value);
    endtask

    // every source in mask starts one frame at the same edge
    task automatic run_frames(input string name, input logic [2:0] mask, input int nbeats,
                              input logic stall);
        link_beat_t exp_q [$];
        link_beat_t exp;
        int         src;
        int         last_src;
        test_tag++;
        got_link.delete();
        last_src = rr_start;
        for (int i = 0; i < 3; i++) begin
            src = (rr_start + i) % 3;
            if (mask[src]) begin
                for (int k = 0; k < nbeats; k++) begin
                    exp.tid  = 2'(src);
                    exp.beat = make_beat(src, k, nbeats);
                    exp_q.push_back(exp);
                end
                last_src = src;
            end
        end
        rr_start = (last_src + 1) % 3;
        fork
            begin
                fork
                    if (mask[0]) send_frame(0, nbeats);
                    if (mask[1]) send_frame(1, nbeats);
                    if (mask[2]) send_frame(2, nbeats);
                join
            end
            begin
                while (got_link.size() < exp_q.size()) begin
                    @(posedge axis_clk);
                    if (stall) link_out_ready <= (($random(seed) & 3) != 0);
                end
                @(posedge axis_clk);
                link_out_ready <= 1'b1;
            end
        join
        repeat (6) @(negedge axis_clk);
        if (got_link.size() != exp_q.size()) begin
            abort_run($sformatf("%s: link output carried more beats than were sent", name));
        end
        foreach (exp_q[i]) check_link_beat(name, exp_q[i], got_link[i]);
    endtask

    task automatic route_mix(input int nbeats);
        src_beat_t  exp_up [$];
        src_beat_t  exp_aa [$];
        link_beat_t beats [$];
        link_beat_t b;
        test_tag++;
        got_up.delete();
        got_aa.delete();
        for (int k = 0; k < nbeats; k++) begin
            b.tid  = 2'($unsigned($random(seed)) % 3);
            b.beat = make_beat(int'(b.tid), k, nbeats);
            beats.push_back(b);
            if (b.tid == 2'd0) exp_up.push_back(b.beat);
            if (b.tid == 2'd1) exp_aa.push_back(b.beat);
        end
        fork
            begin
                foreach (beats[i]) send_link(beats[i]);
                @(posedge axis_clk);
                link_in_valid <= 1'b0;
            end
            begin
                while (got_up.size() < exp_up.size() || got_aa.size() < exp_aa.size()) begin
                    @(posedge axis_clk);
                    up_out_ready <= $random(seed) & 1;
                    aa_out_ready <= $random(seed) & 1;
                end
                @(posedge axis_clk);
                up_out_ready <= 1'b1;
                aa_out_ready <= 1'b1;
            end
        join
        repeat (8) @(negedge axis_clk);
        if (got_up.size() != exp_up.size() || got_aa.size() != exp_aa.size()) begin
            abort_run("route_mix: a downstream port received beats it should not have");
        end
        foreach (exp_up[i]) check_src_beat("route_mix up", exp_up[i], got_up[i]);
        foreach (exp_aa[i]) check_src_beat("route_mix aa", exp_aa[i], got_aa[i]);
    endtask

    task automatic threshold_limit();
        src_beat_t  exp_up [$];
        src_beat_t  exp_aa [$];
        link_beat_t b;
        th_t        value;
        int         accepted;
        logic       saw_low;
        test_tag++;
        lite_write(15'h0, 32'd2, 1'b1);
        sample_th(value);
        check_th("threshold_set", 4'd2, value);
        got_up.delete();
        got_aa.delete();
        accepted = 0;
        saw_low  = 1'b0;
        @(posedge axis_clk);
        up_out_ready <= 1'b0;
        aa_out_ready <= 1'b0;
        // offer beats for a fixed window while both ports stall
        for (int c = 0; c < 12; c++) begin
            b.tid  = 2'(accepted % 2);
            b.beat = make_beat(accepted % 2, accepted, 12);
            @(posedge axis_clk);
            link_in       <= b;
            link_in_valid <= 1'b1;
            @(negedge axis_clk);
            if (link_in_ready) begin
                if (b.tid == 2'd0) exp_up.push_back(b.beat);
                else exp_aa.push_back(b.beat);
                accepted++;
            end else begin
                saw_low = 1'b1;
            end
        end
        @(posedge axis_clk);
        link_in_valid <= 1'b0;
        if (!saw_low) abort_run("threshold: link_in_ready never fell with both ports stalled");
        if (accepted > 4) begin
            abort_run($sformatf("threshold: %0d beats accepted, at most 4 allowed", accepted));
        end
        up_out_ready <= 1'b1;
        aa_out_ready <= 1'b1;
        while (got_up.size() < exp_up.size() || got_aa.size() < exp_aa.size()) begin
            @(negedge axis_clk);
        end
        repeat (4) @(negedge axis_clk);
        if (got_up.size() != exp_up.size() || got_aa.size() != exp_aa.size()) begin
            abort_run("threshold: downstream ports received extra beats");
        end
        foreach (exp_up[i]) check_src_beat("threshold up", exp_up[i], got_up[i]);
        foreach (exp_aa[i]) check_src_beat("threshold aa", exp_aa[i], got_aa[i]);
    endtask

    initial begin
        axi_reset_n    = 1'b0;
        beat_drv[0]    = '0;
        beat_drv[1]    = '0;
        beat_drv[2]    = '0;
        valid_drv      = '0;
        link_out_ready = 1'b1;
        link_in        = '0;
        link_in_valid  = 1'b0;
        up_out_ready   = 1'b1;
        aa_out_ready   = 1'b1;
        lite_wr        = '0;
        lite_awvalid   = 1'b0;
        lite_wvalid    = 1'b0;
        lite_arvalid   = 1'b1;
        lite_rready    = 1'b1;
        cfg_enable     = 1'b0;
        repeat (16) @(posedge axis_clk);
        axi_reset_n <= 1'b1;
        repeat (2) @(posedge axis_clk);
        config_regs();
        run_frames("round_robin_all", 3'b111, 2, 1'b0);
        run_frames("round_robin_0_2", 3'b101, 2, 1'b0);
        run_frames("single_frame", 3'b010, 3, 1'b0);
        run_frames("link_backpressure", 3'b111, 4, 1'b1);
        route_mix(24);
        threshold_limit();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: list.f
+incdir+rtl
+incdir+bench
rtl/axis_pkg.sv
rtl/cfg_pkg.sv
rtl/cfg_lite_regs.sv
rtl/upstream_arbiter.sv
rtl/downstream_fifo.sv
rtl/downstream_router.sv
rtl/axis_switch_top.sv
bench/switch_tb.sv

// File: rtl/axis_pkg.sv
`include "switch_defines.svh"

package axis_pkg;

    // one beat as seen on an upstream source or a downstream port
    typedef struct packed {
        logic [`SW_DATA_WIDTH-1:0] data;
        logic [`SW_KEEP_WIDTH-1:0] keep;
        logic                      last;
        logic [`SW_USER_WIDTH-1:0] user;
    } src_beat_t;

    // serial link beat, tid says which source or port it belongs to
    typedef struct packed {
        logic [`SW_TID_WIDTH-1:0] tid;
        src_beat_t                beat;
    } link_beat_t;

    //////////////////////////////////////////////////
    // tid assignment
    //////////////////////////////////////////////////

    // user project
    localparam logic [`SW_TID_WIDTH-1:0] TID_UP = 2'd0;
    // register bridge
    localparam logic [`SW_TID_WIDTH-1:0] TID_AA = 2'd1;
    // logic analyzer, upstream only
    localparam logic [`SW_TID_WIDTH-1:0] TID_LA = 2'd2;

endpackage

// File: rtl/axis_switch_top.sv
`timescale 1ns/10ps

`include "switch_defines.svh"

module axis_switch_top
    import axis_pkg::*;
    import cfg_pkg::*;
(
    input  logic                      axis_clk,
    input  logic                      axi_reset_n,
    // upstream sources
    input  src_beat_t                 up_beat,
    input  logic                      up_valid,
    output logic                      up_ready,
    input  src_beat_t                 aa_beat,
    input  logic                      aa_valid,
    output logic                      aa_ready,
    input  src_beat_t                 la_beat,
    input  logic                      la_valid,
    output logic                      la_ready,
    // serial link
    output link_beat_t                link_out,
    output logic                      link_out_valid,
    input  logic                      link_out_ready,
    input  link_beat_t                link_in,
    input  logic                      link_in_valid,
    output logic                      link_in_ready,
    // downstream ports
    output src_beat_t                 up_out,
    output logic                      up_out_valid,
    input  logic                      up_out_ready,
    output src_beat_t                 aa_out,
    output logic                      aa_out_valid,
    input  logic                      aa_out_ready,
    // register slave
    input  lite_wr_t                  lite_wr,
    input  logic                      lite_awvalid,
    input  logic                      lite_wvalid,
    output logic                      lite_awready,
    output logic                      lite_wready,
    input  logic                      lite_arvalid,
    output logic                      lite_arready,
    output logic                      lite_rvalid,
    output logic [`SW_DATA_WIDTH-1:0] lite_rdata,
    input  logic                      lite_rready,
    input  logic                      cfg_enable
);

    th_t        threshold;
    link_beat_t head;
    logic       head_valid;
    logic       pop;

    cfg_lite_regs u_cfg (
        .axis_clk     (axis_clk),
        .axi_reset_n  (axi_reset_n),
        .cfg_enable   (cfg_enable),
        .lite_awvalid (lite_awvalid),
        .lite_wvalid  (lite_wvalid),
        .lite_wr      (lite_wr),
        .lite_arvalid (lite_arvalid),
        .lite_rready  (lite_rready),
        .lite_awready (lite_awready),
        .lite_wready  (lite_wready),
        .lite_arready (lite_arready),
        .lite_rvalid  (lite_rvalid),
        .lite_rdata   (lite_rdata),
        .threshold    (threshold)
    );

    upstream_arbiter u_arb (
        .axis_clk       (axis_clk),
        .axi_reset_n    (axi_reset_n),
        .up_beat        (up_beat),
        .aa_beat        (aa_beat),
        .la_beat        (la_beat),
        .up_valid       (up_valid),
        .aa_valid       (aa_valid),
        .la_valid       (la_valid),
        .link_out_ready (link_out_ready),
        .up_ready       (up_ready),
        .aa_ready       (aa_ready),
        .la_ready       (la_ready),
        .link_out       (link_out),
        .link_out_valid (link_out_valid)
    );

    downstream_fifo u_fifo (
        .axis_clk      (axis_clk),
        .axi_reset_n   (axi_reset_n),
        .link_in       (link_in),
        .link_in_valid (link_in_valid),
        .threshold     (threshold),
        .pop           (pop),
        .link_in_ready (link_in_ready),
        .head          (head),
        .head_valid    (head_valid)
    );

    downstream_router u_router (
        .head         (head),
        .head_valid   (head_valid),
        .up_out_ready (up_out_ready),
        .aa_out_ready (aa_out_ready),
        .pop          (pop),
        .up_out       (up_out),
        .aa_out       (aa_out),
        .up_out_valid (up_out_valid),
        .aa_out_valid (aa_out_valid)
    );

endmodule

// File: rtl/cfg_lite_regs.sv
`timescale 1ns/10ps

`include "switch_defines.svh"

module cfg_lite_regs
    import cfg_pkg::*;
(
    input  logic                      axis_clk,
    input  logic                      axi_reset_n,
    input  logic                      cfg_enable,
    input  logic                      lite_awvalid,
    input  logic                      lite_wvalid,
    input  lite_wr_t                  lite_wr,
    input  logic                      lite_arvalid,
    input  logic                      lite_rready,
    output logic                      lite_awready,
    output logic                      lite_wready,
    output logic                      lite_arready,
    output logic                      lite_rvalid,
    output logic [`SW_DATA_WIDTH-1:0] lite_rdata,
    output th_t                       threshold
);

    localparam int DW = `SW_DATA_WIDTH;

    logic wr_fire;
    logic reg_hit;

    // address and data must arrive together
    assign wr_fire = cfg_enable && lite_awvalid && lite_wvalid;
    // only word 0 exists, low byte holds the threshold
    assign reg_hit = (lite_wr.addr[11:2] == '0) && lite_wr.strb[0];

    assign lite_awready = wr_fire;
    assign lite_wready  = wr_fire;

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            threshold <= th_t'(`SW_TH_RESET);
        end else if (wr_fire && reg_hit) begin
            threshold <= lite_wr.data[$bits(th_t)-1:0];
        end
    end

    // read side answers at once, every address returns word 0
    assign lite_arready = 1'b1;
    assign lite_rvalid  = 1'b1;
    assign lite_rdata   = DW'(threshold);

endmodule

// File: rtl/cfg_pkg.sv
`include "switch_defines.svh"

package cfg_pkg;

    // write address and data, taken in one cycle
    typedef struct packed {
        logic [`SW_LITE_ADDR_WIDTH-1:0] addr;
        logic [`SW_DATA_WIDTH-1:0]      data;
        logic [`SW_DATA_WIDTH/8-1:0]    strb;
    } lite_wr_t;

    // fill level above which the link input is throttled
    typedef logic [`SW_TH_WIDTH-1:0] th_t;

endpackage

// File: rtl/downstream_fifo.sv
`timescale 1ns/10ps

`include "switch_defines.svh"

module downstream_fifo
    import axis_pkg::*;
    import cfg_pkg::*;
(
    input  logic       axis_clk,
    input  logic       axi_reset_n,
    input  link_beat_t link_in,
    input  logic       link_in_valid,
    input  th_t        threshold,
    input  logic       pop,
    output logic       link_in_ready,
    output link_beat_t head,
    output logic       head_valid
);

    localparam int DEPTH = `SW_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = AW + 1;

    link_beat_t    mem [DEPTH];
    logic [CW-1:0] wr_ptr;
    logic [CW-1:0] rd_ptr;
    logic [CW-1:0] wr_ptr_next;
    logic [CW-1:0] rd_ptr_next;
    logic [CW-1:0] fill_next;
    logic          wr_en;

    assign wr_en       = link_in_valid && link_in_ready;
    assign wr_ptr_next = wr_ptr + CW'(wr_en);
    assign rd_ptr_next = rd_ptr + CW'(pop);
    // extra pointer bit tells full from empty
    assign fill_next   = wr_ptr_next - rd_ptr_next;

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            link_in_ready <= 1'b0;
        end else begin
            wr_ptr        <= wr_ptr_next;
            rd_ptr        <= rd_ptr_next;
            // one beat of slack above the threshold
            link_in_ready <= (fill_next <= CW'(threshold));
        end
    end

    always_ff @(posedge axis_clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= link_in;
        end
    end

    assign head       = mem[rd_ptr[AW-1:0]];
    assign head_valid = (wr_ptr != rd_ptr);

endmodule

// File: rtl/downstream_router.sv
`timescale 1ns/10ps

module downstream_router
    import axis_pkg::*;
(
    input  link_beat_t head,
    input  logic       head_valid,
    input  logic       up_out_ready,
    input  logic       aa_out_ready,
    output logic       pop,
    output src_beat_t  up_out,
    output src_beat_t  aa_out,
    output logic       up_out_valid,
    output logic       aa_out_valid
);

    logic up_sel;
    logic aa_sel;
    logic drop;

    assign up_sel = (head.tid == TID_UP);
    assign aa_sel = (head.tid == TID_AA);
    // no downstream port for la or the spare tid
    assign drop   = head_valid && !up_sel && !aa_sel;

    assign up_out_valid = head_valid && up_sel;
    assign aa_out_valid = head_valid && aa_sel;

    // unselected port sees all zeros
    assign up_out = up_sel ? head.beat : '0;
    assign aa_out = aa_sel ? head.beat : '0;

    //////////////////////////////////////////////////
    // buffer pop
    //////////////////////////////////////////////////

    assign pop = (up_out_valid && up_out_ready)
               || (aa_out_valid && aa_out_ready)
               || drop;

endmodule

// File: rtl/switch_defines.svh
`ifndef SWITCH_DEFINES_SVH
`define SWITCH_DEFINES_SVH

//////////////////////////////////////////////////
// stream beat fields
//////////////////////////////////////////////////

`define SW_DATA_WIDTH 32
// one keep bit per data byte
`define SW_KEEP_WIDTH 4
`define SW_USER_WIDTH 2
`define SW_TID_WIDTH 2

//////////////////////////////////////////////////
// switch structure
//////////////////////////////////////////////////

// up, aa and la
`define SW_NUM_SOURCES 3
`define SW_FIFO_DEPTH 16

// register slave
`define SW_LITE_ADDR_WIDTH 15
`define SW_TH_WIDTH 4
`define SW_TH_RESET 6

`endif

// File: rtl/upstream_arbiter.sv
`timescale 1ns/10ps

`include "switch_defines.svh"

module upstream_arbiter
    import axis_pkg::*;
(
    input  logic       axis_clk,
    input  logic       axi_reset_n,
    input  src_beat_t  up_beat,
    input  src_beat_t  aa_beat,
    input  src_beat_t  la_beat,
    input  logic       up_valid,
    input  logic       aa_valid,
    input  logic       la_valid,
    input  logic       link_out_ready,
    output logic       up_ready,
    output logic       aa_ready,
    output logic       la_ready,
    output link_beat_t link_out,
    output logic       link_out_valid
);

    localparam int N  = `SW_NUM_SOURCES;
    localparam int PW = $clog2(N);

    // tid stamped on the link for each source index
    localparam logic [`SW_TID_WIDTH-1:0] SRC_TID [N] = '{TID_UP, TID_AA, TID_LA};

    logic [N-1:0]  req;
    src_beat_t     src_beat [N];
    logic [N-1:0]  src_ready;
    logic [PW-1:0] grant_idx;
    logic [PW-1:0] base_ptr;
    logic          frame_active;
    logic          stage_free;
    logic          accept;
    logic          pick_found;
    logic [PW-1:0] pick_idx;
    logic [PW-1:0] pick_next;

    assign req         = {la_valid, aa_valid, up_valid};
    assign src_beat[0] = up_beat;
    assign src_beat[1] = aa_beat;
    assign src_beat[2] = la_beat;

    //////////////////////////////////////////////////
    // round robin pick
    //////////////////////////////////////////////////

    // search starts one past the last winner
    always_comb begin
        int idx;
        pick_found = 1'b0;
        pick_idx   = '0;
        for (int i = 0; i < N; i++) begin
            idx = (int'(base_ptr) + i) % N;
            if (!pick_found && req[idx]) begin
                pick_found = 1'b1;
                pick_idx   = PW'(idx);
            end
        end
        pick_next = (pick_idx == PW'(N - 1)) ? '0 : pick_idx + 1'b1;
    end

    // stage can take a beat when empty or draining this cycle
    assign stage_free = !link_out_valid || link_out_ready;

    always_comb begin
        src_ready = '0;
        if (frame_active && stage_free) begin
            src_ready[grant_idx] = 1'b1;
        end
    end

    assign up_ready = src_ready[0];
    assign aa_ready = src_ready[1];
    assign la_ready = src_ready[2];
    assign accept   = |(src_ready & req);

    //////////////////////////////////////////////////
    // grant lock and output stage
    //////////////////////////////////////////////////

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            frame_active   <= 1'b0;
            grant_idx      <= '0;
            base_ptr       <= '0;
            link_out_valid <= 1'b0;
        end else begin
            if (!frame_active) begin
                if (pick_found) begin
                    frame_active <= 1'b1;
                    grant_idx    <= pick_idx;
                    base_ptr     <= pick_next;
                end
            end else if (accept && src_beat[grant_idx].last) begin
                // frame done, re-arbitrate next cycle
                frame_active <= 1'b0;
            end

            if (accept) begin
                link_out_valid <= 1'b1;
            end else if (link_out_ready) begin
                link_out_valid <= 1'b0;
            end
        end
    end

    // held while the link back-pressures
    always_ff @(posedge axis_clk) begin
        if (accept) begin
            link_out.beat <= src_beat[grant_idx];
            link_out.tid  <= SRC_TID[grant_idx];
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the switch testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module switch_tb \
    -f list.f --Mdir obj_dir -o switch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/switch_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
